//--- cpu_mem_pkg.sv
// load/store encodings, AXI-lite window and bus widths
// packed structs passed between the data-memory stages
`default_nettype none

package cpu_mem_pkg;

  localparam int ADDR_WIDTH = 32;
  localparam int BUS_WIDTH  = 32;
  localparam int STRB_WIDTH = BUS_WIDTH / 8;

  // peripheral window, 4 KiB at 0x4000_0000
  localparam logic [ADDR_WIDTH-1:0] AXIL_BASE = 32'h4000_0000;
  localparam logic [ADDR_WIDTH-1:0] AXIL_MASK = 32'hffff_f000;

  typedef enum logic [2:0] {
    LOAD_NONE   = 3'd0,
    LOAD_BYTE   = 3'd1,
    LOAD_HALF   = 3'd2,
    LOAD_WORD   = 3'd3,
    LOAD_BYTE_U = 3'd4,
    LOAD_HALF_U = 3'd5
  } load_type_t;

  typedef enum logic [1:0] {
    STORE_NONE = 2'd0,
    STORE_BYTE = 2'd1,
    STORE_HALF = 2'd2,
    STORE_WORD = 2'd3
  } store_type_t;

  // operation from the execute stage
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    load_type_t            ltype;
    store_type_t           stype;
    logic [BUS_WIDTH-1:0]  wdata;
  } mem_op_t;

  // MEM1 slot, address region already resolved
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    load_type_t            ltype;
    store_type_t           stype;
    logic [BUS_WIDTH-1:0]  wdata;
    logic                  in_window;
  } mem1_op_t;

  typedef struct packed {
    logic                  start_read;
    logic                  start_write;
    logic [ADDR_WIDTH-1:0] raddr;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [BUS_WIDTH-1:0]  wdata;
    logic [STRB_WIDTH-1:0] wstrb;
  } axil_start_t;

  typedef struct packed {
    logic                 done_read;
    logic                 done_write;
    logic [BUS_WIDTH-1:0] rdata;
  } axil_done_t;

  // master-driven AXI-lite channels
  typedef struct packed {
    logic                  awvalid;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  wvalid;
    logic [BUS_WIDTH-1:0]  wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  // slave-driven AXI-lite channels
  typedef struct packed {
    logic                 awready;
    logic                 wready;
    logic                 bvalid;
    logic [1:0]           bresp;
    logic                 arready;
    logic                 rvalid;
    logic [BUS_WIDTH-1:0] rdata;
    logic [1:0]           rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- mem_addr_decode.sv
// MEM1 pipeline register
// loads the incoming operation and resolves its address region
`timescale 1ns/1ps
`default_nettype none

module mem_addr_decode
  import cpu_mem_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  mem_op_t  op_in,
  input  logic     stall,
  output logic     in_ready,
  output mem1_op_t mem1
);

  logic                  valid_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  load_type_t            ltype_q;
  store_type_t           stype_q;
  logic [BUS_WIDTH-1:0]  wdata_q;
  logic                  in_window_q;
  logic                  hit;

  // upstream may hand over a new op whenever MEM1 is free to move
  assign in_ready = !stall;

  // peripheral window match on the incoming address
  assign hit = (op_in.addr & AXIL_MASK) == AXIL_BASE;

  // slot valid, cleared on cycles with nothing accepted
  always_ff @(posedge CLK) begin
    if (RST) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= op_in.valid;
    end
  end

  // operation fields
  always_ff @(posedge CLK) begin
    if (!stall && op_in.valid) begin
      addr_q      <= op_in.addr;
      ltype_q     <= op_in.ltype;
      stype_q     <= op_in.stype;
      wdata_q     <= op_in.wdata;
      in_window_q <= hit;
    end
  end

  always_comb begin
    mem1.valid     = valid_q;
    mem1.addr      = addr_q;
    mem1.ltype     = ltype_q;
    mem1.stype     = stype_q;
    mem1.wdata     = wdata_q;
    mem1.in_window = in_window_q;
  end

endmodule

`default_nettype wire

//--- axil_interface.sv
// AXI-lite start-pulse generator for MEM1
// read/write pending flags and the pipeline stall level
`timescale 1ns/1ps
`default_nettype none

module axil_interface
  import cpu_mem_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  mem1_op_t    mem1,
  input  axil_done_t  done,
  output axil_start_t start,
  output logic        stall
);

  logic active;
  logic rreq;
  logic wreq;
  logic rreq_pending;
  logic wreq_pending;

  // only word accesses inside the window go out on the bus
  assign active = mem1.valid && mem1.in_window &&
                  (mem1.ltype == LOAD_WORD || mem1.stype == STORE_WORD);

  assign rreq = active && (mem1.ltype == LOAD_WORD);
  assign wreq = active && (mem1.stype == STORE_WORD);

  // read pending, set with the start pulse and dropped by done
  always_ff @(posedge CLK) begin
    if (RST) begin
      rreq_pending <= 1'b0;
    end else if (done.done_read) begin
      rreq_pending <= 1'b0;
    end else if (rreq && !rreq_pending) begin
      rreq_pending <= 1'b1;
    end
  end

  // write pending
  always_ff @(posedge CLK) begin
    if (RST) begin
      wreq_pending <= 1'b0;
    end else if (done.done_write) begin
      wreq_pending <= 1'b0;
    end else if (wreq && !wreq_pending) begin
      wreq_pending <= 1'b1;
    end
  end

  always_comb begin
    if (active) begin
      start.start_read  = rreq && !rreq_pending;
      start.start_write = wreq && !wreq_pending;
      start.raddr       = mem1.addr;
      start.waddr       = mem1.addr;
      start.wdata       = mem1.wdata;
      start.wstrb       = '1;
    end else begin
      start.start_read  = 1'b0;
      start.start_write = 1'b0;
      start.raddr       = '0;
      start.waddr       = '0;
      start.wdata       = '0;
      start.wstrb       = '0;
    end
  end

  // hold the pipe until the matching done shows up;
  // the done cycle itself lets the next op in
  assign stall = (rreq && !done.done_read) || (wreq && !done.done_write);

endmodule

`default_nettype wire

//--- axil_master.sv
// AXI-lite master with independent read and write sequencers
// driven by start pulses, returns done pulses and read data
`timescale 1ns/1ps
`default_nettype none

module axil_master
  import cpu_mem_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  axil_start_t start,
  output axil_done_t  done,
  output axil_req_t   bus_req,
  input  axil_rsp_t   bus_rsp
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_ADDR,
    R_DATA
  } rd_state_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_ADDR,
    W_RESP
  } wr_state_t;

  rd_state_t             rd_state;
  wr_state_t             wr_state;
  logic [ADDR_WIDTH-1:0] raddr_q;
  logic [ADDR_WIDTH-1:0] waddr_q;
  logic [BUS_WIDTH-1:0]  wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;
  logic [BUS_WIDTH-1:0]  rdata_q;
  logic                  aw_done;
  logic                  w_done;
  logic                  done_read_q;
  logic                  done_write_q;
  logic                  aw_hs;
  logic                  w_hs;

  assign aw_hs = bus_req.awvalid && bus_rsp.awready;
  assign w_hs  = bus_req.wvalid && bus_rsp.wready;

  // read path: idle -> address -> data
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_state    <= R_IDLE;
      done_read_q <= 1'b0;
    end else begin
      done_read_q <= 1'b0;
      case (rd_state)
        R_IDLE: if (start.start_read) rd_state <= R_ADDR;
        R_ADDR: if (bus_rsp.arready) rd_state <= R_DATA;
        R_DATA: begin
          if (bus_rsp.rvalid) begin
            rd_state    <= R_IDLE;
            done_read_q <= 1'b1;
          end
        end
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // read address and returned data
  always_ff @(posedge CLK) begin
    if (rd_state == R_IDLE && start.start_read) begin
      raddr_q <= start.raddr;
    end
    if (rd_state == R_DATA && bus_rsp.rvalid) begin
      rdata_q <= bus_rsp.rdata;
    end
  end

  // write path: AW and W may be accepted in either order
  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_state     <= W_IDLE;
      aw_done      <= 1'b0;
      w_done       <= 1'b0;
      done_write_q <= 1'b0;
    end else begin
      done_write_q <= 1'b0;
      case (wr_state)
        W_IDLE: if (start.start_write) wr_state <= W_ADDR;
        W_ADDR: begin
          if ((aw_done || aw_hs) && (w_done || w_hs)) begin
            wr_state <= W_RESP;
            aw_done  <= 1'b0;
            w_done   <= 1'b0;
          end else begin
            aw_done <= aw_done || aw_hs;
            w_done  <= w_done || w_hs;
          end
        end
        W_RESP: begin
          if (bus_rsp.bvalid) begin
            wr_state     <= W_IDLE;
            done_write_q <= 1'b1;
          end
        end
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_state == W_IDLE && start.start_write) begin
      waddr_q <= start.waddr;
      wdata_q <= start.wdata;
      wstrb_q <= start.wstrb;
    end
  end

  always_comb begin
    bus_req.arvalid = (rd_state == R_ADDR);
    bus_req.araddr  = raddr_q;
    bus_req.rready  = 1'b1;
    bus_req.awvalid = (wr_state == W_ADDR) && !aw_done;
    bus_req.awaddr  = waddr_q;
    bus_req.wvalid  = (wr_state == W_ADDR) && !w_done;
    bus_req.wdata   = wdata_q;
    bus_req.wstrb   = wstrb_q;
    bus_req.bready  = 1'b1;
  end

  // response codes are not checked
  always_comb begin
    done.done_read  = done_read_q;
    done.done_write = done_write_q;
    done.rdata      = rdata_q;
  end

endmodule

`default_nettype wire

//--- mem_stage_top.sv
// data-memory stage top level
// MEM1 register, start-pulse generator and AXI-lite master
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top
  import cpu_mem_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  mem_op_t              op_in,
  output logic                 in_ready,
  output axil_req_t            bus_req,
  input  axil_rsp_t            bus_rsp,
  output logic                 load_valid,
  output logic [BUS_WIDTH-1:0] load_data
);

  mem1_op_t    mem1;
  logic        stall;
  axil_start_t start;
  axil_done_t  done;

  mem_addr_decode mem_addr_decode_i (
    .CLK      (CLK),
    .RST      (RST),
    .op_in    (op_in),
    .stall    (stall),
    .in_ready (in_ready),
    .mem1     (mem1)
  );

  axil_interface axil_interface_i (
    .CLK   (CLK),
    .RST   (RST),
    .mem1  (mem1),
    .done  (done),
    .start (start),
    .stall (stall)
  );

  axil_master axil_master_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .done    (done),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

  // read completion goes straight back to the pipeline
  assign load_valid = done.done_read;
  assign load_data  = done.rdata;

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #HALF_PERIOD CLK = ~CLK;
  end

  // reset held for the first few rising edges
  initial begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

//--- mem_stage_chk.sv
// assertions on the AXI-lite start pulses, pending flags and stall
// bound onto axil_interface
`timescale 1ns/1ps
`default_nettype none

module mem_stage_chk
  import cpu_mem_pkg::*;
(
  input logic        CLK,
  input logic        RST,
  input axil_start_t start,
  input axil_done_t  done,
  input logic        stall,
  input logic        rreq_pending,
  input logic        wreq_pending
);

  int   fail_count = 0;
  logic rd_open;
  logic wr_open;

  // requests that have started and not yet seen their done pulse
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_open <= 1'b0;
      wr_open <= 1'b0;
    end else begin
      if (start.start_read)
        rd_open <= 1'b1;
      else if (done.done_read)
        rd_open <= 1'b0;
      if (start.start_write)
        wr_open <= 1'b1;
      else if (done.done_write)
        wr_open <= 1'b0;
    end
  end

  // every start lasts exactly one cycle
  read_single_pulse: assert property (@(posedge CLK) disable iff (RST)
      start.start_read |=> !start.start_read)
    else begin
      $error("start_read held for more than one cycle");
      fail_count++;
    end

  write_single_pulse: assert property (@(posedge CLK) disable iff (RST)
      start.start_write |=> !start.start_write)
    else begin
      $error("start_write held for more than one cycle");
      fail_count++;
    end

  // an outstanding request blocks a second start until its done
  no_start_while_pending: assert property (@(posedge CLK) disable iff (RST)
      (rd_open |-> !start.start_read) and (wr_open |-> !start.start_write))
    else begin
      $error("start pulse while its request is pending");
      fail_count++;
    end

  idle_after_reset: assert property (@(posedge CLK)
      RST |=> (!stall && !rreq_pending && !wreq_pending))
    else begin
      $error("stall or pending flag high after reset");
      fail_count++;
    end

endmodule

bind axil_interface mem_stage_chk mem_stage_chk_i (
  .CLK          (CLK),
  .RST          (RST),
  .start        (start),
  .done         (done),
  .stall        (stall),
  .rreq_pending (rreq_pending),
  .wreq_pending (wreq_pending)
);

`default_nettype wire

//--- tb_mem_stage.sv
// testbench for the data-memory stage
// LFSR stimulus, AXI-lite slave memory model, reference model and checks
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage
  import cpu_mem_pkg::*;
();

  localparam int NUM_RANDOM      = 200;
  localparam int NUM_OPS         = NUM_RANDOM + 2;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 12 + 200;
  localparam int MEM_WORDS       = 1024;

  typedef enum logic [1:0] {
    PEND_NONE,
    PEND_READ,
    PEND_WRITE
  } pend_t;

  logic                 CLK;
  logic                 RST;
  mem_op_t              op_in;
  logic                 in_ready;
  axil_req_t            bus_req;
  axil_rsp_t            bus_rsp;
  logic                 load_valid;
  logic [BUS_WIDTH-1:0] load_data;

  logic [31:0] stim_lfsr  = 32'h543b;
  logic [31:0] slave_lfsr = 32'h543b;
  logic [31:0] slave_mem [MEM_WORDS];
  logic [31:0] exp_mem [MEM_WORDS];
  logic [31:0] exp_q [$];
  pend_t       pend_kind = PEND_NONE;
  logic [31:0] cur_addr;
  logic [31:0] cur_wdata;
  logic        b_last = 1'b0;
  logic        r_last = 1'b0;
  logic        exp_ready;
  int          n_checks = 0;
  int          n_errors = 0;
  int          n_exp_rd = 0;
  int          n_exp_wr = 0;
  int          n_ar = 0;
  int          n_r = 0;
  int          n_load = 0;
  int          n_aw = 0;
  int          n_w = 0;
  int          n_b = 0;

  // slave model state
  logic [31:0] ar_wait;
  logic [31:0] r_wait;
  logic [31:0] aw_wait;
  logic [31:0] w_wait;
  logic [31:0] b_wait;
  logic [31:0] r_addr;
  logic [31:0] w_addr;
  logic [31:0] w_data;
  logic [3:0]  w_strb;
  logic        r_pend;
  logic        aw_got;
  logic        w_got;

  tb_clk_gen clk_gen_i (
    .CLK (CLK),
    .RST (RST)
  );

  mem_stage_top mem_stage_top_i (
    .CLK        (CLK),
    .RST        (RST),
    .op_in      (op_in),
    .in_ready   (in_ready),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      state = lfsr_step(state);
      v = {v[30:0], state[0]};
    end
  endtask

  function automatic logic [31:0] fill_word(input int idx);
    logic [31:0] a;
    a = AXIL_BASE + 32'(idx) * 4;
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic in_window(input logic [31:0] addr);
    return (addr & AXIL_MASK) == AXIL_BASE;
  endfunction

  // only word stores inside the window change the reference memory
  function automatic logic [31:0] model_mem_op(input mem_op_t op);
    if (!in_window(op.addr)) begin
      return '0;
    end
    if (op.stype == STORE_WORD) begin
      exp_mem[op.addr[11:2]] = op.wdata;
    end
    return exp_mem[op.addr[11:2]];
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic flag_failure(input string what);
    n_errors++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic record_accept(input mem_op_t op);
    logic [31:0] data;
    data = model_mem_op(op);
    if (in_window(op.addr) && op.ltype == LOAD_WORD) begin
      exp_q.push_back(data);
      pend_kind = PEND_READ;
      n_exp_rd++;
    end else if (in_window(op.addr) && op.stype == STORE_WORD) begin
      pend_kind = PEND_WRITE;
      n_exp_wr++;
    end
    cur_addr  = op.addr;
    cur_wdata = op.wdata;
  endtask

  task automatic make_op(output mem_op_t op);
    logic [31:0] r;
    logic [31:0] kind;
    op = '0;
    op.valid = 1'b1;
    // 16 words only, so loads often hit earlier stores
    draw_bits(stim_lfsr, 4, r);
    op.addr = AXIL_BASE + (r << 2);
    draw_bits(stim_lfsr, 32, r);
    op.wdata = r;
    draw_bits(stim_lfsr, 3, kind);
    case (kind)
      0, 1, 2: op.ltype = LOAD_WORD;
      3, 4, 5: op.stype = STORE_WORD;
      6: begin
        draw_bits(stim_lfsr, 3, r);
        case (r)
          0: op.ltype = LOAD_BYTE;
          1: op.ltype = LOAD_HALF;
          2: op.ltype = LOAD_BYTE_U;
          3: op.ltype = LOAD_HALF_U;
          4, 5: op.stype = STORE_BYTE;
          default: op.stype = STORE_HALF;
        endcase
      end
      default: begin
        // word access at 0x8000_0000 and above lies outside the window
        draw_bits(stim_lfsr, 32, r);
        op.addr = {1'b1, r[30:0]};
        if (r[31])
          op.ltype = LOAD_WORD;
        else
          op.stype = STORE_WORD;
      end
    endcase
  endtask

  // holds the op on op_in until the DUT takes it
  task automatic send_op(input mem_op_t op);
    logic [31:0] gap;
    logic        taken;
    draw_bits(stim_lfsr, 2, gap);
    if (gap == 0) begin
      op_in <= '0;
      @(posedge CLK);
    end
    op_in <= op;
    taken = 1'b0;
    while (!taken) begin
      @(negedge CLK);
      taken = in_ready;
      @(posedge CLK);
    end
    op_in <= '0;
  endtask

  initial begin
    bus_rsp = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      slave_mem[i] = fill_word(i);
      exp_mem[i]   = fill_word(i);
    end
  end

  // AXI-lite slave with 0 to 3 cycles before each ready and each response
  always @(posedge CLK) begin
    if (RST) begin
      bus_rsp <= '0;
      ar_wait = '0;
      r_wait  = '0;
      aw_wait = '0;
      w_wait  = '0;
      b_wait  = '0;
      r_pend  = 1'b0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
    end else begin
      if (bus_req.arvalid && bus_rsp.arready) begin
        bus_rsp.arready <= 1'b0;
        r_addr = bus_req.araddr;
        r_pend = 1'b1;
        draw_bits(slave_lfsr, 2, ar_wait);
      end else if (bus_req.arvalid) begin
        if (ar_wait == 0)
          bus_rsp.arready <= 1'b1;
        else
          ar_wait = ar_wait - 1;
      end
      if (bus_rsp.rvalid && bus_req.rready) begin
        bus_rsp.rvalid <= 1'b0;
      end else if (r_pend) begin
        if (r_wait == 0) begin
          bus_rsp.rvalid <= 1'b1;
          bus_rsp.rdata  <= slave_mem[r_addr[11:2]];
          r_pend = 1'b0;
          draw_bits(slave_lfsr, 2, r_wait);
        end else begin
          r_wait = r_wait - 1;
        end
      end
      if (bus_req.awvalid && bus_rsp.awready) begin
        bus_rsp.awready <= 1'b0;
        w_addr = bus_req.awaddr;
        aw_got = 1'b1;
        draw_bits(slave_lfsr, 2, aw_wait);
      end else if (bus_req.awvalid) begin
        if (aw_wait == 0)
          bus_rsp.awready <= 1'b1;
        else
          aw_wait = aw_wait - 1;
      end
      if (bus_req.wvalid && bus_rsp.wready) begin
        bus_rsp.wready <= 1'b0;
        w_data = bus_req.wdata;
        w_strb = bus_req.wstrb;
        w_got  = 1'b1;
        draw_bits(slave_lfsr, 2, w_wait);
      end else if (bus_req.wvalid) begin
        if (w_wait == 0)
          bus_rsp.wready <= 1'b1;
        else
          w_wait = w_wait - 1;
      end
      // memory is written when the response goes out
      if (bus_rsp.bvalid && bus_req.bready) begin
        bus_rsp.bvalid <= 1'b0;
      end else if (aw_got && w_got) begin
        if (b_wait == 0) begin
          for (int k = 0; k < STRB_WIDTH; k++) begin
            if (w_strb[k])
              slave_mem[w_addr[11:2]][8*k +: 8] = w_data[8*k +: 8];
          end
          bus_rsp.bvalid <= 1'b1;
          aw_got = 1'b0;
          w_got  = 1'b0;
          draw_bits(slave_lfsr, 2, b_wait);
        end else begin
          b_wait = b_wait - 1;
        end
      end
    end
  end

  // compare process sampling mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      // in_ready comes back only in the cycle of the matching done
      case (pend_kind)
        PEND_READ:  exp_ready = r_last;
        PEND_WRITE: exp_ready = b_last;
        default:    exp_ready = 1'b1;
      endcase
      check_val("in_ready", exp_ready, in_ready);
      if (exp_ready) begin
        pend_kind = PEND_NONE;
      end
      if (bus_req.arvalid && pend_kind != PEND_READ) begin
        flag_failure("arvalid raised with no word load pending");
      end
      if ((bus_req.awvalid || bus_req.wvalid) && pend_kind != PEND_WRITE) begin
        flag_failure("awvalid or wvalid raised with no word store pending");
      end
      if (bus_req.arvalid && bus_rsp.arready) begin
        n_ar++;
        check_val("araddr", cur_addr, bus_req.araddr);
      end
      if (bus_rsp.rvalid && bus_req.rready) begin
        n_r++;
      end
      if (bus_req.awvalid && bus_rsp.awready) begin
        n_aw++;
        check_val("awaddr", cur_addr, bus_req.awaddr);
      end
      if (bus_req.wvalid && bus_rsp.wready) begin
        n_w++;
        check_val("wdata", cur_wdata, bus_req.wdata);
        check_val("wstrb", {STRB_WIDTH{1'b1}}, bus_req.wstrb);
      end
      if (bus_rsp.bvalid && bus_req.bready) begin
        n_b++;
      end
      // load_valid follows the R handshake by one cycle
      check_val("load_valid", r_last, load_valid);
      if (load_valid) begin
        n_load++;
        if (exp_q.size() == 0)
          flag_failure("load_valid seen with no load outstanding");
        else
          check_val("load_data", exp_q.pop_front(), load_data);
      end
      b_last = bus_rsp.bvalid && bus_req.bready;
      r_last = bus_rsp.rvalid && bus_req.rready;
      if (op_in.valid && in_ready) begin
        record_accept(op_in);
      end
    end
  end

  initial begin
    mem_op_t op;
    int      chk_fails;
    op_in = '0;
    @(posedge CLK);
    while (RST) @(posedge CLK);
    @(negedge CLK);
    check_val("in_ready", 1'b1, in_ready);
    check_val("arvalid", 1'b0, bus_req.arvalid);
    check_val("awvalid", 1'b0, bus_req.awvalid);
    check_val("wvalid", 1'b0, bus_req.wvalid);
    check_val("rready", 1'b1, bus_req.rready);
    check_val("bready", 1'b1, bus_req.bready);
    check_val("load_valid", 1'b0, load_valid);
    @(posedge CLK);
    // store then load of the same word
    op = '0;
    op.valid = 1'b1;
    op.addr  = AXIL_BASE + 32'h40;
    op.stype = STORE_WORD;
    op.wdata = 32'hc0de_1234;
    send_op(op);
    op.stype = STORE_NONE;
    op.ltype = LOAD_WORD;
    op.wdata = '0;
    send_op(op);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      make_op(op);
      send_op(op);
    end
    while (exp_q.size() != 0 || pend_kind != PEND_NONE) @(posedge CLK);
    repeat (4) @(posedge CLK);
    check_val("ar_count", n_exp_rd, n_ar);
    check_val("r_count", n_exp_rd, n_r);
    check_val("load_valid_count", n_exp_rd, n_load);
    check_val("aw_count", n_exp_wr, n_aw);
    check_val("w_count", n_exp_wr, n_w);
    check_val("b_count", n_exp_wr, n_b);
    chk_fails = mem_stage_top_i.axil_interface_i.mem_stage_chk_i.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, chk_fails);
    if (n_errors == 0 && chk_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: operations did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
cpu_mem_pkg.sv
mem_addr_decode.sv
axil_interface.sv
axil_master.sv
mem_stage_top.sv
tb_clk_gen.sv
mem_stage_chk.sv
tb_mem_stage.sv
